// File: int_pipeline_top.f
design/int_core_pkg.sv
design/decode_stage.sv
design/register_file.sv
design/operand_stage.sv
design/execute_stage.sv
design/int_pipeline_top.sv
bench/int_pipeline_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the pipeline testbench with Verilator and runs it from the project root
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
  --top-module int_pipeline_tb \
  -f int_pipeline_top.f \
  -o int_pipeline_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/int_pipeline_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q "All checks passed" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi

// File: bench/int_pipeline_stimulus.txt
# valid inst pc block clear | retires test rd write illegal value (all hex)
# lines that retire nothing carry zeros in the expect columns
1 06400093 00000100 0 0 1 1 01 1 0 00000064
1 ff900113 00000104 0 0 1 1 02 1 0 fffffff9
1 00300193 00000108 0 0 1 1 03 1 0 00000003
1 00208233 0000010c 0 0 1 1 04 1 0 0000005d
1 402082b3 00000110 0 0 1 1 05 1 0 0000006b
1 00309333 00000114 0 0 1 1 06 1 0 00000320
1 001123b3 00000118 0 0 1 1 07 1 0 00000001
1 00113433 0000011c 0 0 1 1 08 1 0 00000000
1 0020c4b3 00000120 0 0 1 1 09 1 0 ffffff9d
1 00315533 00000124 0 0 1 1 0a 1 0 1fffffff
1 403155b3 00000128 0 0 1 1 0b 1 0 ffffffff
1 0030e633 0000012c 0 0 1 1 0c 1 0 00000067
1 0020f6b3 00000130 0 0 1 1 0d 1 0 00000060
1 fff08713 00000134 0 0 1 2 0e 1 0 00000063
1 00513793 00000138 0 0 1 2 0f 1 0 00000000
1 40115813 0000013c 0 0 1 2 10 1 0 fffffffc
1 123458b7 00000140 0 0 1 2 11 1 0 12345000
1 00001917 00000144 0 0 1 2 12 1 0 00001144
1 00500993 00000148 0 0 1 3 13 1 0 00000005
1 01398a33 0000014c 0 0 1 3 14 1 0 0000000a
1 01498ab3 00000150 0 0 1 3 15 1 0 0000000f
1 00098b33 00000154 0 0 1 3 16 1 0 00000005
1 00798013 00000158 0 0 1 3 00 0 0 0000000c
1 01500bb3 0000015c 0 0 1 3 17 1 0 0000000f
1 00000c33 00000160 0 0 1 3 18 1 0 00000000
1 00100c93 00000164 0 0 1 4 19 1 0 00000001
1 002c8d13 00000168 0 0 1 4 1a 1 0 00000003
0 00000000 00000000 1 0 0 0 00 0 0 00000000
0 00000000 00000000 1 0 0 0 00 0 0 00000000
0 00000000 00000000 1 0 0 0 00 0 0 00000000
0 00000000 00000000 1 0 0 0 00 0 0 00000000
1 003d0d93 0000016c 0 0 1 4 1b 1 0 00000006
1 00900e13 00000170 0 0 1 5 1c 1 0 00000009
0 00000000 00000000 0 0 0 0 00 0 0 00000000
0 00000000 00000000 0 0 0 0 00 0 0 00000000
0 00000000 00000000 0 0 0 0 00 0 0 00000000
1 04d00e13 00000174 0 0 0 0 00 0 0 00000000
1 05800e93 00000178 0 1 0 0 00 0 0 00000000
0 00000000 00000000 0 0 0 0 00 0 0 00000000
1 01de0f33 0000017c 0 0 1 5 1e 1 0 00000009
1 0000a083 00000180 0 0 1 6 01 0 1 00000000
1 022080b3 00000184 0 0 1 6 01 0 1 00000000
1 00008fb3 00000188 0 0 1 6 1f 1 0 00000064

// File: bench/int_pipeline_tb.sv
module int_pipeline_tb import int_core_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  // one stimulus line applied for one cycle
  typedef struct packed {
    logic  inst_valid;
    word_t inst;
    word_t pc;
    logic  block;
    logic  clear;
  } drive_t;

  // one retire record in acceptance order
  typedef struct packed {
    logic [7:0] test_id;
    word_t      pc;
    reg_addr_t  rd;
    logic       write;
    logic       illegal;
    word_t      value;
  } expect_t;

  logic      clock = 1'b0;
  logic      reset;
  logic      inst_valid;
  word_t     inst;
  word_t     pc;
  logic      block;
  logic      clear_pipeline;
  logic      retire_valid;
  word_t     retire_pc;
  reg_addr_t retire_rd;
  logic      retire_write;
  logic      retire_illegal;
  word_t     retire_value;

  drive_t  drive_q[$];
  expect_t expect_q[$];
  int      last_of_test[1:6] = '{default: -1};
  int      test_errors[1:6] = '{default: 0};
  int      retire_errors = 0;
  int      checks = 0;
  int      checked = 0;
  int      cycles = 0;
  int      limit = 100000;
  logic    open_failed = 1'b0;

  always #5 clock = ~clock;

  int_pipeline_top dut0 (
    .clock          (clock),
    .reset          (reset),
    .inst_valid     (inst_valid),
    .inst           (inst),
    .pc             (pc),
    .block          (block),
    .clear_pipeline (clear_pipeline),
    .retire_valid   (retire_valid),
    .retire_pc      (retire_pc),
    .retire_rd      (retire_rd),
    .retire_write   (retire_write),
    .retire_illegal (retire_illegal),
    .retire_value   (retire_value)
  );

  function automatic string test_name(input int id);
    case (id)
      1:       return "reg_reg_alu";
      2:       return "immediate_ops";
      3:       return "forwarding_x0";
      4:       return "block_freeze";
      5:       return "clear_squash";
      default: return "illegal_encoding";
    endcase
  endfunction

  task automatic compare(input int id, input string field, input word_t expected,
                         input word_t actual);
    checks++;
    if (expected !== actual) begin
      $display("FAIL %s %s expected %h actual %h", test_name(id), field, expected, actual);
      retire_errors++;
      test_errors[id]++;
    end
  endtask

  task automatic load_stimulus();
    int fd;
    int n;
    string line;
    logic [31:0] v, ins, p, blk, clr, ret, tid, rd, wr, ill, val;
    drive_t d;
    expect_t e;
    fd = $fopen("bench/int_pipeline_stimulus.txt", "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file");
      open_failed = 1'b1;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
                  v, ins, p, blk, clr, ret, tid, rd, wr, ill, val);
      // comment and blank lines do not scan
      if (n == 11) begin
        d.inst_valid = v[0];
        d.inst       = ins;
        d.pc         = p;
        d.block      = blk[0];
        d.clear      = clr[0];
        drive_q.push_back(d);
        if (ret[0]) begin
          e.test_id = tid[7:0];
          e.pc      = p;
          e.rd      = rd[4:0];
          e.write   = wr[0];
          e.illegal = ill[0];
          e.value   = val;
          expect_q.push_back(e);
          last_of_test[tid[2:0]] = expect_q.size() - 1;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic check_retire();
    expect_t e;
    int id;
    if (expect_q.size() == 0) begin
      $display("unexpected retire at pc %h", retire_pc);
      retire_errors++;
    end else begin
      e = expect_q.pop_front();
      id = int'(e.test_id);
      compare(id, "pc", e.pc, retire_pc);
      compare(id, "rd", {27'b0, e.rd}, {27'b0, retire_rd});
      compare(id, "write", {31'b0, e.write}, {31'b0, retire_write});
      compare(id, "illegal", {31'b0, e.illegal}, {31'b0, retire_illegal});
      // the result of an illegal encoding has no meaning
      if (!e.illegal) begin
        compare(id, "value", e.value, retire_value);
      end
      if (checked == last_of_test[id]) begin
        $display("test %s done, %0d errors", test_name(id), test_errors[id]);
      end
      checked++;
    end
  endtask

  // retire outputs settle well before the falling edge
  always @(negedge clock) begin
    if (!reset && retire_valid) begin
      check_retire();
    end
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles >= limit) begin
      $display("timeout after %0d cycles, pipeline did not drain", cycles);
      $display("Checks failed");
      $finish;
    end
  end

  task automatic run_tests();
    int idle;
    int missing;
    limit = 4 * drive_q.size() + 100;
    repeat (8) @(posedge clock);
    #1;
    reset = 1'b0;
    foreach (drive_q[i]) begin
      @(posedge clock);
      #1;
      inst_valid     = drive_q[i].inst_valid;
      inst           = drive_q[i].inst;
      pc             = drive_q[i].pc;
      block          = drive_q[i].block;
      clear_pipeline = drive_q[i].clear;
    end
    @(posedge clock);
    #1;
    inst_valid     = 1'b0;
    block          = 1'b0;
    clear_pipeline = 1'b0;
    idle = 0;
    while (expect_q.size() > 0 && idle < 20) begin
      @(posedge clock);
      idle++;
    end
    repeat (2) @(posedge clock);
    missing = expect_q.size();
    if (missing > 0) begin
      $display("%0d expected retires never came", missing);
    end
    $display("checks %0d, retire errors %0d, missing %0d", checks, retire_errors, missing);
    if (retire_errors == 0 && missing == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
  endtask

  initial begin
    reset          = 1'b1;
    inst_valid     = 1'b0;
    inst           = '0;
    pc             = '0;
    block          = 1'b0;
    clear_pipeline = 1'b0;
    load_stimulus();
    if (open_failed) begin
      $display("Checks failed");
    end else begin
      run_tests();
    end
    $finish;
  end

endmodule

// File: design/int_pipeline_top.sv
module int_pipeline_top import int_core_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      inst_valid,
  input  word_t     inst,
  input  word_t     pc,
  input  logic      block,
  input  logic      clear_pipeline,
  output logic      retire_valid,
  output word_t     retire_pc,
  output reg_addr_t retire_rd,
  output logic      retire_write,
  output logic      retire_illegal,
  output word_t     retire_value
);

  decoded_t   decoded;
  reg_addr_t  rs1;
  reg_addr_t  rs2;
  word_t      rdata1;
  word_t      rdata2;
  issue_t     issue;
  writeback_t ex_bypass;
  writeback_t wb;

  decode_stage decode_stage0 (
    .clock          (clock),
    .reset          (reset),
    .block          (block),
    .clear_pipeline (clear_pipeline),
    .inst_valid     (inst_valid),
    .inst           (inst),
    .pc             (pc),
    .decoded        (decoded)
  );

  operand_stage operand_stage0 (
    .clock          (clock),
    .reset          (reset),
    .block          (block),
    .clear_pipeline (clear_pipeline),
    .decoded        (decoded),
    .rs1            (rs1),
    .rs2            (rs2),
    .rdata1         (rdata1),
    .rdata2         (rdata2),
    .ex_bypass      (ex_bypass),
    .wb             (wb),
    .issue          (issue)
  );

  register_file register_file0 (
    .clock  (clock),
    .reset  (reset),
    .block  (block),
    .rs1    (rs1),
    .rs2    (rs2),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .wb     (wb)
  );

  execute_stage execute_stage0 (
    .clock        (clock),
    .reset        (reset),
    .block        (block),
    .issue        (issue),
    .ex_bypass    (ex_bypass),
    .wb           (wb),
    .retire_valid (retire_valid)
  );

  // retire port is the writeback record
  assign retire_pc      = wb.pc;
  assign retire_rd      = wb.rd;
  assign retire_write   = wb.reg_write;
  assign retire_illegal = wb.illegal;
  assign retire_value   = wb.result;

endmodule

// File: design/execute_stage.sv
module execute_stage import int_core_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       block,
  input  issue_t     issue,
  output writeback_t ex_bypass,
  output writeback_t wb,
  output logic       retire_valid
);

  word_t      op_a;
  word_t      op_b;
  logic [4:0] shamt;
  word_t      result;

  assign op_a  = issue.operand_a;
  assign op_b  = issue.operand_b;
  // shifts only look at the low five bits of B
  assign shamt = op_b[4:0];

  always_comb begin
    case (issue.alu_op)
      alu_add:    result = op_a + op_b;
      alu_sub:    result = op_a - op_b;
      alu_sll:    result = op_a << shamt;
      alu_slt:    result = {31'b0, $signed(op_a) < $signed(op_b)};
      alu_sltu:   result = {31'b0, op_a < op_b};
      alu_xor:    result = op_a ^ op_b;
      alu_srl:    result = op_a >> shamt;
      alu_sra:    result = $signed(op_a) >>> shamt;
      alu_or:     result = op_a | op_b;
      alu_and:    result = op_a & op_b;
      alu_pass_b: result = op_b;
      default:    result = '0;
    endcase
  end

  // current result, forwarded to the operand stage in the same cycle
  always_comb begin
    ex_bypass.valid     = issue.valid;
    ex_bypass.pc        = issue.pc;
    ex_bypass.rd        = issue.rd;
    ex_bypass.reg_write = issue.reg_write;
    ex_bypass.illegal   = issue.illegal;
    ex_bypass.result    = result;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wb.valid <= 1'b0;
    end else if (!block) begin
      wb <= ex_bypass;
    end
  end

  // a frozen record is reported once, on its unblocked cycle
  assign retire_valid = wb.valid && !block;

endmodule

// File: design/operand_stage.sv
module operand_stage import int_core_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       block,
  input  logic       clear_pipeline,
  input  decoded_t   decoded,
  output reg_addr_t  rs1,
  output reg_addr_t  rs2,
  input  word_t      rdata1,
  input  word_t      rdata2,
  input  writeback_t ex_bypass,
  input  writeback_t wb,
  output issue_t     issue
);

  word_t  src1;
  word_t  src2;
  word_t  operand_a;
  issue_t issue_next;

  // freshest value of one source, near is the younger producer
  function automatic word_t forward(
    input reg_addr_t  idx,
    input word_t      rf_value,
    input writeback_t near,
    input writeback_t far
  );
    word_t value;
    value = rf_value;
    if (idx != '0) begin
      if (near.valid && near.reg_write && near.rd == idx) begin
        value = near.result;
      end else if (far.valid && far.reg_write && far.rd == idx) begin
        value = far.result;
      end
    end
    return value;
  endfunction

  assign rs1 = decoded.rs1;
  assign rs2 = decoded.rs2;

  assign src1 = forward(decoded.rs1, rdata1, ex_bypass, wb);
  assign src2 = forward(decoded.rs2, rdata2, ex_bypass, wb);

  always_comb begin
    case (decoded.a_sel)
      a_pc:    operand_a = decoded.pc;
      a_zero:  operand_a = '0;
      default: operand_a = src1;
    endcase
  end

  always_comb begin
    issue_next.valid     = decoded.valid && !clear_pipeline;
    issue_next.pc        = decoded.pc;
    issue_next.rd        = decoded.rd;
    issue_next.reg_write = decoded.reg_write;
    issue_next.illegal   = decoded.illegal;
    issue_next.alu_op    = decoded.alu_op;
    issue_next.operand_a = operand_a;
    issue_next.operand_b = decoded.b_is_imm ? decoded.imm : src2;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      issue.valid <= 1'b0;
    end else if (!block) begin
      issue <= issue_next;
    end
  end

endmodule

// File: design/register_file.sv
module register_file import int_core_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       block,
  input  reg_addr_t  rs1,
  input  reg_addr_t  rs2,
  output word_t      rdata1,
  output word_t      rdata2,
  input  writeback_t wb
);

  // x1 to x31, x0 has no storage
  word_t regs [1:31];
  logic  write_en;

  assign write_en = wb.valid && wb.reg_write && (wb.rd != '0) && !block;

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en) begin
      regs[wb.rd] <= wb.result;
    end
  end

  // combinational reads, forwarding sits in the operand stage
  assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: design/decode_stage.sv
module decode_stage import int_core_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  logic     block,
  input  logic     clear_pipeline,
  input  logic     inst_valid,
  input  word_t    inst,
  input  word_t    pc,
  output decoded_t decoded
);

  word_t      inst_q;
  word_t      pc_q;
  logic       valid_q;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_u;

  logic       known;
  alu_op_t    alu_op;
  operand_a_t a_sel;
  logic       b_is_imm;
  logic       use_imm_u;

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else if (!block) begin
      valid_q <= inst_valid && !clear_pipeline;
    end
  end

  always_ff @(posedge clock) begin
    if (!block) begin
      inst_q <= inst;
      pc_q   <= pc;
    end
  end

  assign opcode = inst_q[6:0];
  assign funct3 = inst_q[14:12];
  assign funct7 = inst_q[31:25];

  assign imm_i = {{20{inst_q[31]}}, inst_q[31:20]};
  assign imm_u = {inst_q[31:12], 12'b0};

  always_comb begin
    known     = 1'b1;
    alu_op    = alu_add;
    a_sel     = a_reg;
    b_is_imm  = 1'b0;
    use_imm_u = 1'b0;
    case (opcode)
      // lui is 0 + imm, passed straight through
      op_lui: begin
        alu_op    = alu_pass_b;
        a_sel     = a_zero;
        b_is_imm  = 1'b1;
        use_imm_u = 1'b1;
      end
      op_auipc: begin
        a_sel     = a_pc;
        b_is_imm  = 1'b1;
        use_imm_u = 1'b1;
      end
      op_imm: begin
        b_is_imm = 1'b1;
        case (funct3)
          3'b000: alu_op = alu_add;
          3'b001: begin
            alu_op = alu_sll;
            known  = (funct7 == funct7_base);
          end
          3'b010: alu_op = alu_slt;
          3'b011: alu_op = alu_sltu;
          3'b100: alu_op = alu_xor;
          3'b101: begin
            alu_op = funct7[5] ? alu_sra : alu_srl;
            known  = (funct7 == funct7_base) || (funct7 == funct7_alt);
          end
          3'b110: alu_op = alu_or;
          default: alu_op = alu_and;
        endcase
      end
      op_reg: begin
        case (funct3)
          3'b000: alu_op = funct7[5] ? alu_sub : alu_add;
          3'b001: alu_op = alu_sll;
          3'b010: alu_op = alu_slt;
          3'b011: alu_op = alu_sltu;
          3'b100: alu_op = alu_xor;
          3'b101: alu_op = funct7[5] ? alu_sra : alu_srl;
          3'b110: alu_op = alu_or;
          default: alu_op = alu_and;
        endcase
        // only add/sub and the right shifts have an alternate form
        known = (funct7 == funct7_base) ||
                ((funct7 == funct7_alt) && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      default: known = 1'b0;
    endcase
  end

  always_comb begin
    decoded.valid     = valid_q;
    decoded.pc        = pc_q;
    decoded.rs1       = inst_q[19:15];
    decoded.rs2       = inst_q[24:20];
    decoded.rd        = inst_q[11:7];
    // x0 as destination retires without a write
    decoded.reg_write = valid_q && known && (inst_q[11:7] != '0);
    decoded.illegal   = valid_q && !known;
    decoded.alu_op    = alu_op;
    decoded.a_sel     = a_sel;
    decoded.b_is_imm  = b_is_imm;
    decoded.imm       = use_imm_u ? imm_u : imm_i;
  end

endmodule

// File: design/int_core_pkg.sv
package int_core_pkg;

  // data, pc and instruction words
  typedef logic [31:0] word_t;
  // register index
  typedef logic [4:0]  reg_addr_t;

  // major opcodes of the supported RV32I subset
  localparam logic [6:0] op_lui   = 7'b0110111;
  localparam logic [6:0] op_auipc = 7'b0010111;
  localparam logic [6:0] op_imm   = 7'b0010011;
  localparam logic [6:0] op_reg   = 7'b0110011;

  // funct7 values, alt selects SUB and SRA/SRAI
  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt  = 7'b0100000;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_t;

  // source of ALU operand A
  typedef enum logic [1:0] {
    a_reg,
    a_pc,
    a_zero
  } operand_a_t;

  // output of the decode register
  typedef struct packed {
    logic       valid;
    word_t      pc;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    logic       reg_write;
    logic       illegal;
    alu_op_t    alu_op;
    operand_a_t a_sel;
    logic       b_is_imm;
    word_t      imm;
  } decoded_t;

  // contents of the issue register, operands already resolved
  typedef struct packed {
    logic      valid;
    word_t     pc;
    reg_addr_t rd;
    logic      reg_write;
    logic      illegal;
    alu_op_t   alu_op;
    word_t     operand_a;
    word_t     operand_b;
  } issue_t;

  typedef struct packed {
    logic      valid;
    word_t     pc;
    reg_addr_t rd;
    logic      reg_write;
    logic      illegal;
    word_t     result;
  } writeback_t;

endpackage
